// File: sources.f
rtc_pkg.sv
rtc_cmd_deser.sv
rtc_pacer.sv
rtc_time_core.sv
rtc_status_gen.sv
rtc_top.sv
tb_rtc.sv

// File: Makefile
# Verilator simulation of the real-time clock testbench

VERILATOR ?= verilator
TOP       ?= tb_rtc
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_rtc.sv
/*
 * testbench for the real-time clock with clocks, command and status tasks,
 * a stimulus table for time set, rate, rollover and correction, status packets
 */
`default_nettype none

module tb_rtc
    import rtc_pkg::*;
();

    localparam logic [15:0] BASE       = 16'h0704;   // matches RTC_ADDR below
    localparam logic [7:0]  STAT_ADDR  = 8'h31;
    localparam int          CYC_PER_US = 12;         // refclk period 240 and two edges per tick
    localparam int          NROWS      = 11;

    typedef struct packed {
        logic [1:0]  sel;        // register index
        logic [31:0] data;
        int          wait_us;    // run time after the write or 0 for no time check
        int          exp_sec;
        int          exp_usec;
        int          tol;        // allowed error in microseconds
    } row_t;

    logic              mclk;
    logic              rst;
    logic              refclk;
    logic [7:0]        cmd_ad;
    logic              cmd_stb;
    logic [7:0]        status_ad;
    logic              status_rq;
    logic              status_start;
    logic [SEC_W-1:0]  live_sec;
    logic [USEC_W-1:0] live_usec;

    row_t              rows [NROWS];
    int                errors;
    int                r;
    logic [31:0]       rnd_state;
    logic [USEC_W-1:0] pend_usec;        // last usec written
    logic              exp_snap;         // model of the snapshot bit
    logic [5:0]        pk_seq  [3];      // expected packet contents
    logic [SEC_W-1:0]  pk_sec  [3];
    logic [USEC_W-1:0] pk_usec [3];
    logic              pk_snap [3];

    rtc_top #(
        .RTC_ADDR    (16'h0704),
        .RTC_MASK    (16'h07fc),
        .RTC_MHZ     (2),
        .STATUS_ADDR (8'h31)
    ) u_dut (
        .mclk         (mclk),
        .rst          (rst),
        .refclk       (refclk),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start),
        .live_sec     (live_sec),
        .live_usec    (live_usec)
    );

    initial begin
        mclk = 1'b0;
        forever #20 mclk = ~mclk;
    end

    initial begin
        refclk = 1'b0;
        forever #120 refclk = ~refclk;   // toggles on mclk falling edges
    end

    task automatic stop_run(input string why);
        errors = errors + 1;
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input longint got, input longint exp,
                         input longint tol);
        longint diff;
        diff = got - exp;
        if (diff > tol || diff < -tol) begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // microseconds counted in n_us at rate (2^23 + corr) / 2^23
    function automatic longint rate_count(input int n_us, input int corr);
        return (longint'(n_us) * (longint'(1 << 23) + longint'(corr))) / longint'(1 << 23);
    endfunction

    function automatic row_t make_row(input logic [1:0] sel, input logic [31:0] data,
                                      input int wait_us, input int exp_sec,
                                      input int exp_usec, input int tol);
        row_t t;
        t = '{sel: sel, data: data, wait_us: wait_us, exp_sec: exp_sec,
              exp_usec: exp_usec, tol: tol};
        return t;
    endfunction

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [7:0] b [CMD_BYTES];
        int i;
        b[0] = addr[7:0];        // little-endian address
        b[1] = addr[15:8];
        b[2] = data[7:0];
        b[3] = data[15:8];
        b[4] = data[23:16];
        b[5] = data[31:24];
        for (i = 0; i < CMD_BYTES; i++) begin
            @(posedge mclk);
            cmd_ad  <= b[i];
            cmd_stb <= (i == 0);     // strobe with first byte only
        end
        @(posedge mclk);
        cmd_ad  <= 8'h00;
        cmd_stb <= 1'b0;
    endtask

    task automatic wait_sec(input logic [SEC_W-1:0] value);
        int n;
        n = 0;
        do begin
            @(negedge mclk);
            n++;
        end while (live_sec != value && n < 200);
        if (live_sec != value)
            stop_run("timeout waiting for the seconds value to load");
    endtask

    task automatic wait_rq();
        int n;
        n = 0;
        do begin
            @(negedge mclk);
            n++;
        end while (!status_rq && n < 50);
        if (!status_rq)
            stop_run("timeout waiting for status_rq");
    endtask

    task automatic apply_row(input row_t row);
        send_cmd(BASE | {14'd0, row.sel}, row.data);
        if (row.sel == REG_USEC) begin
            pend_usec = row.data[USEC_W-1:0];
        end else if (row.sel == REG_SEC) begin
            wait_sec(row.data);                // load latency varies
            check("live_usec", longint'(live_usec), longint'(pend_usec), 0);
        end
        if (row.wait_us > 0) begin
            repeat (row.wait_us * CYC_PER_US) @(posedge mclk);
            @(negedge mclk);
            check("live_sec", longint'(live_sec), longint'(row.exp_sec), 0);
            check("live_usec", longint'(live_usec), longint'(row.exp_usec),
                  longint'(row.tol));
        end
    endtask

    // status write and live time sampled in the reg_we cycle
    task automatic request_status(input int idx);
        logic [5:0] seq;
        rnd_state = next_random(rnd_state);
        seq = rnd_state[5:0];
        send_cmd(BASE | {14'd0, REG_STATUS}, {26'd0, seq});
        @(negedge mclk);
        exp_snap     = ~exp_snap;
        pk_seq[idx]  = seq;
        pk_sec[idx]  = live_sec;
        pk_usec[idx] = live_usec;
        pk_snap[idx] = exp_snap;
    endtask

    task automatic receive_packet(input int idx);
        logic [7:0] exp_b [1:STATUS_BYTES-1];
        int j;
        exp_b[1] = {pk_seq[idx], pk_snap[idx], 1'b0};
        for (j = 0; j < 4; j++)
            exp_b[2+j] = pk_sec[idx][8*j +: 8];
        exp_b[6] = pk_usec[idx][7:0];
        exp_b[7] = pk_usec[idx][15:8];
        exp_b[8] = {4'h0, pk_usec[idx][19:16]};  // zero-extended to 24 bits
        wait_rq();
        check("status_ad", longint'(status_ad), longint'(STAT_ADDR), 0);
        @(posedge mclk);
        status_start <= 1'b1;
        @(posedge mclk);
        status_start <= 1'b0;
        for (j = 1; j < STATUS_BYTES; j++) begin
            @(negedge mclk);
            check("status_rq", longint'(status_rq), 0, 0);
            check("status_ad", longint'(status_ad), longint'(exp_b[j]), 0);
        end
    endtask

    initial begin
        int cyc;
        for (cyc = 0; cyc < 100000; cyc++)
            @(posedge mclk);
        stop_run("simulation ran past its cycle limit");
    end

    initial begin
        rst          = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        errors       = 0;
        rnd_state    = 32'd17755;
        pend_usec    = '0;
        exp_snap     = 1'b0;

        rows[0]  = make_row(REG_USEC, 32'd12345, 0, 0, 0, 0);
        rows[1]  = make_row(REG_SEC, 32'd7, 50, 7, 12395, 1);       // nominal rate
        rows[2]  = make_row(REG_USEC, 32'd999990, 0, 0, 0, 0);
        rows[3]  = make_row(REG_SEC, 32'd100, 20, 101, 10, 1);      // rollover
        rows[4]  = make_row(REG_CORR, 32'h0000_4000, 0, 0, 0, 0);
        rows[5]  = make_row(REG_USEC, 32'd0, 0, 0, 0, 0);
        rows[6]  = make_row(REG_SEC, 32'd200, 2000, 200, int'(rate_count(2000, 16384)), 2);
        rows[7]  = make_row(REG_CORR, 32'hffff_c000, 0, 0, 0, 0);   // -16384
        rows[8]  = make_row(REG_USEC, 32'd0, 0, 0, 0, 0);
        rows[9]  = make_row(REG_SEC, 32'd300, 2000, 300, int'(rate_count(2000, -16384)), 2);
        rows[10] = make_row(REG_CORR, 32'd0, 0, 0, 0, 0);

        repeat (3) @(posedge mclk);
        rst <= 1'b0;
        @(negedge mclk);
        check("live_sec", longint'(live_sec), 0, 0);
        check("live_usec", longint'(live_usec), 0, 0);
        check("status_rq", longint'(status_rq), 0, 0);

        // writes outside the address window leave the clock stopped at zero
        send_cmd(16'h0710, 32'h0000_1234);
        send_cmd(16'h0711, 32'h0000_0055);
        repeat (4 * CYC_PER_US) @(posedge mclk);
        @(negedge mclk);
        check("live_sec", longint'(live_sec), 0, 0);
        check("live_usec", longint'(live_usec), 0, 0);

        for (r = 0; r < NROWS; r++)
            apply_row(rows[r]);

        request_status(0);
        receive_packet(0);
        request_status(1);
        fork
            receive_packet(1);
            begin
                wait_rq();
                request_status(2);     // lands mid-packet and is held by the DUT
            end
        join
        receive_packet(2);
        @(negedge mclk);
        check("status_rq", longint'(status_rq), 0, 0);

        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtc_top.sv
/*
 * rtc_top: command deserializer, pacer, time core
 * and status generator of the microsecond real-time clock
 */
`default_nettype none

module rtc_top
    import rtc_pkg::*;
#(
    parameter logic [15:0] RTC_ADDR    = 16'h0704,
    parameter logic [15:0] RTC_MASK    = 16'h07fc,
    parameter int          RTC_MHZ     = 25,
    parameter logic [7:0]  STATUS_ADDR = 8'h31
) (
    input  wire               mclk,
    input  wire               rst,
    input  wire               refclk,
    input  wire  [7:0]        cmd_ad,
    input  wire               cmd_stb,
    output logic [7:0]        status_ad,
    output logic              status_rq,
    input  wire               status_start,
    output logic [SEC_W-1:0]  live_sec,
    output logic [USEC_W-1:0] live_usec
);

    logic [1:0]  reg_sel;
    logic [31:0] reg_data;
    logic        reg_we;
    logic        half_tick;
    logic        run;

    rtc_cmd_deser #(
        .RTC_ADDR (RTC_ADDR),
        .RTC_MASK (RTC_MASK)
    ) u_cmd_deser (
        .mclk     (mclk),
        .rst      (rst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .reg_sel  (reg_sel),
        .reg_data (reg_data),
        .reg_we   (reg_we)
    );

    rtc_pacer #(
        .RTC_MHZ   (RTC_MHZ)
    ) u_pacer (
        .mclk      (mclk),
        .rst       (rst),
        .refclk    (refclk),
        .run       (run),
        .half_tick (half_tick)
    );

    rtc_time_core u_time_core (
        .mclk      (mclk),
        .rst       (rst),
        .reg_sel   (reg_sel),
        .reg_data  (reg_data),
        .reg_we    (reg_we),
        .half_tick (half_tick),
        .run       (run),
        .live_sec  (live_sec),
        .live_usec (live_usec)
    );

    rtc_status_gen #(
        .STATUS_ADDR  (STATUS_ADDR)
    ) u_status_gen (
        .mclk         (mclk),
        .rst          (rst),
        .reg_sel      (reg_sel),
        .reg_data     (reg_data[7:0]),   // only seq byte needed
        .reg_we       (reg_we),
        .live_sec     (live_sec),
        .live_usec    (live_usec),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

`default_nettype wire

// File: rtc_status_gen.sv
/*
 * rtc_status_gen: time snapshot, sequence and toggle bits,
 * status request and byte-serial packet transmitter
 */
`default_nettype none

module rtc_status_gen
    import rtc_pkg::*;
#(
    parameter logic [7:0] STATUS_ADDR = 8'h31   // first packet byte
) (
    input  wire               mclk,
    input  wire               rst,
    input  wire  [1:0]        reg_sel,
    input  wire  [7:0]        reg_data,     // seq in bits 5:0
    input  wire               reg_we,
    input  wire  [SEC_W-1:0]  live_sec,
    input  wire  [USEC_W-1:0] live_usec,
    output logic [7:0]        status_ad,
    output logic              status_rq,
    input  wire               status_start  // grant, seen with address byte
);

    localparam int TX_W  = 8 * (STATUS_BYTES - 1);
    localparam int CNT_W = $clog2(STATUS_BYTES);

    logic              status_wr;
    logic [SEC_W-1:0]  snap_sec;
    logic [USEC_W-1:0] snap_usec;
    logic              snap_bit;       // toggles per snapshot
    logic [5:0]        seq;
    logic [TX_W-1:0]   tx_sr;          // bytes 1..8, next one in low byte
    logic [CNT_W-1:0]  byte_cnt;       // 0 = idle, else byte being sent
    logic              sending;
    logic              granted;
    logic              busy;
    logic              last_byte;
    logic              pend;           // request held during a packet

    assign status_wr = reg_we && (reg_sel == REG_STATUS);
    assign sending   = byte_cnt != '0;
    assign granted   = status_rq && status_start;
    assign busy      = sending || granted;
    assign last_byte = byte_cnt == CNT_W'(STATUS_BYTES - 1);

    // snapshot and packet shifter
    always_ff @(posedge mclk) begin
        if (status_wr) begin
            snap_sec  <= live_sec;
            snap_usec <= live_usec;
            seq       <= reg_data[5:0];
        end
        if (granted)
            tx_sr <= {{(24-USEC_W){1'b0}}, snap_usec, snap_sec, seq, snap_bit, 1'b0};
        else if (sending)
            tx_sr <= {8'h00, tx_sr[TX_W-1:8]};
    end

    // request, hold and byte counter
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            snap_bit  <= 1'b0;
            status_rq <= 1'b0;
            pend      <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            if (status_wr) snap_bit <= ~snap_bit;

            if (granted)
                status_rq <= 1'b0;
            else if (status_wr && !busy)
                status_rq <= 1'b1;
            else if (last_byte && (pend || status_wr))
                status_rq <= 1'b1;                 // held request after packet

            if (last_byte)              pend <= 1'b0;
            else if (status_wr && busy) pend <= 1'b1;

            if (granted)        byte_cnt <= CNT_W'(1);
            else if (last_byte) byte_cnt <= '0;
            else if (sending)   byte_cnt <= byte_cnt + 1'b1;
        end
    end

    assign status_ad = status_rq ? STATUS_ADDR :
                       sending   ? tx_sr[7:0]  : 8'h00;

    // request and payload never overlap on status_ad
    a_rq_idle : assert property (
        @(posedge mclk) disable iff (rst)
        sending |-> !status_rq
    );

endmodule

`default_nettype wire

// File: rtc_time_core.sv
/*
 * write registers, correction accumulator,
 * microsecond and second counters with deferred time load
 */
`default_nettype none

module rtc_time_core
    import rtc_pkg::*;
(
    input  wire               mclk,
    input  wire               rst,
    input  wire  [1:0]        reg_sel,
    input  wire  [31:0]       reg_data,
    input  wire               reg_we,
    input  wire               half_tick,
    output logic              run,          // enables the pacer
    output logic [SEC_W-1:0]  live_sec,
    output logic [USEC_W-1:0] live_usec
);

    logic              wr_usec;
    logic              wr_sec;
    logic              wr_corr;
    logic [USEC_W-1:0] wusec;           // pending microseconds
    logic [SEC_W-1:0]  wsec;            // pending seconds
    logic [CORR_W-1:0] corr;            // signed
    logic              pend;            // sec written, waiting for tick
    logic              load;            // armed, loads on next tick
    logic [ACC_W-1:0]  acc;
    logic [ACC_W-1:0]  step;            // 2^23 + corr
    logic [ACC_W:0]    next_acc;
    logic              carry;
    logic [1:0]        inc_usec;        // carry pipeline
    logic [1:0]        inc_sec;
    logic [USEC_W-1:0] usec_plus1;
    logic [SEC_W-1:0]  sec_plus1;

    assign wr_usec = reg_we && (reg_sel == REG_USEC);
    assign wr_sec  = reg_we && (reg_sel == REG_SEC);
    assign wr_corr = reg_we && (reg_sel == REG_CORR);

    // half of full scale per tick plus sign-extended correction
    assign step     = {~corr[CORR_W-1], {(ACC_W-CORR_W-1){corr[CORR_W-1]}}, corr};
    assign next_acc = {1'b0, acc} + {1'b0, step};
    assign carry    = half_tick && !load && next_acc[ACC_W]; // one per us nominal

    // pending time and precomputed increments
    always_ff @(posedge mclk) begin
        if (wr_usec) wusec <= reg_data[USEC_W-1:0];
        if (wr_sec)  wsec  <= reg_data[SEC_W-1:0];
        usec_plus1 <= live_usec + 1'b1;
        sec_plus1  <= live_sec + 1'b1;
    end

    // run flag, load sequencing, accumulator and carry pipe
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            corr     <= '0;
            run      <= 1'b0;
            pend     <= 1'b0;
            load     <= 1'b0;
            acc      <= '0;
            inc_usec <= '0;
            inc_sec  <= '0;
        end else begin
            if (wr_corr) corr <= reg_data[CORR_W-1:0];
            if (wr_sec)  run  <= 1'b1;           // stays on until reset

            if (wr_sec)         pend <= 1'b1;
            else if (half_tick) pend <= 1'b0;
            if (half_tick)      load <= pend;    // arm on first tick

            if (half_tick) acc <= load ? '0 : next_acc[ACC_W-1:0];

            inc_usec <= {inc_usec[0], carry};
            inc_sec  <= {inc_sec[0], carry && (live_usec == USEC_MAX)};
        end
    end

    // microsecond and second counters
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            live_usec <= '0;
            live_sec  <= '0;
        end else if (half_tick && load) begin
            live_usec <= wusec;          // second tick after the write
            live_sec  <= wsec;
        end else if (inc_sec[1]) begin
            live_usec <= '0;             // wrap
            live_sec  <= sec_plus1;
        end else if (inc_usec[1]) begin
            live_usec <= usec_plus1;
        end
    end

    // loads and increments keep the count in range
    a_usec_range : assert property (
        @(posedge mclk) disable iff (rst)
        live_usec <= USEC_MAX
    );

endmodule

`default_nettype wire

// File: rtc_pacer.sv
/*
 * rtc_pacer: refclk synchronizer, edge counter and
 * half-microsecond tick generator
 */
`default_nettype none

module rtc_pacer #(
    parameter int RTC_MHZ = 25    // refclk frequency, integer MHz
) (
    input  wire  mclk,
    input  wire  rst,
    input  wire  refclk,          // slow, below mclk/2
    input  wire  run,             // pacer held cleared while low
    output logic half_tick        // one pulse per 0.5 us
);

    localparam int CNT_W = $clog2(RTC_MHZ + 1);

    logic [2:0]       ref_sync;   // synchronizer chain
    logic             ref_edge;   // either edge of refclk
    logic [CNT_W-1:0] edge_cnt;   // edges left in this half-us

    assign ref_edge = ref_sync[2] ^ ref_sync[1];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ref_sync  <= '0;
            edge_cnt  <= CNT_W'(RTC_MHZ);
            half_tick <= 1'b0;
        end else begin
            ref_sync  <= {ref_sync[1:0], refclk};
            half_tick <= run && ref_edge && (edge_cnt == CNT_W'(1));
            if (!run) begin
                edge_cnt <= CNT_W'(RTC_MHZ);    // restart phase on next run
            end else if (ref_edge) begin
                if (edge_cnt == CNT_W'(1))
                    edge_cnt <= CNT_W'(RTC_MHZ);  // reload at tick
                else
                    edge_cnt <= edge_cnt - 1'b1;
            end
        end
    end

    // edges are at least two mclk apart, so are ticks
    a_tick_gap : assert property (
        @(posedge mclk) disable iff (rst)
        half_tick |=> !half_tick
    );

endmodule

`default_nettype wire

// File: rtc_cmd_deser.sv
/*
 * rtc_cmd_deser: byte-serial command deserializer
 * collects six bytes, matches address against base/mask, pulses reg_we
 */
`default_nettype none

module rtc_cmd_deser
    import rtc_pkg::*;
#(
    parameter logic [15:0] RTC_ADDR = 16'h0704,  // base address
    parameter logic [15:0] RTC_MASK = 16'h07fc   // address bits that must match
) (
    input  wire        mclk,
    input  wire        rst,
    input  wire  [7:0] cmd_ad,     // address/data byte
    input  wire        cmd_stb,    // with first byte only
    output logic [1:0] reg_sel,
    output logic [31:0] reg_data,
    output logic       reg_we
);

    localparam int SR_W  = 8 * CMD_BYTES;
    localparam int CNT_W = $clog2(CMD_BYTES);

    logic [SR_W-1:0]  cmd_sr;       // byte 0 ends up in the low byte
    logic [CNT_W-1:0] byte_cnt;     // 0 = idle
    logic             cmd_done;     // full command in cmd_sr
    logic [15:0]      cmd_addr;
    logic             addr_hit;

    // command assembly
    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt != '0)) begin
            cmd_sr <= {cmd_ad, cmd_sr[SR_W-1:8]}; // new byte enters at top
        end
    end

    // byte counter and completion flag
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= '0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (cmd_stb) begin
                byte_cnt <= CNT_W'(1);        // first byte taken
            end else if (byte_cnt == CNT_W'(CMD_BYTES - 1)) begin
                byte_cnt <= '0;               // sixth byte taken
                cmd_done <= 1'b1;
            end else if (byte_cnt != '0) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // little-endian address in the two low bytes
    assign cmd_addr = cmd_sr[15:0];
    assign addr_hit = ((cmd_addr ^ RTC_ADDR) & RTC_MASK) == 16'h0000;

    assign reg_sel  = cmd_addr[1:0];          // register index
    assign reg_data = cmd_sr[SR_W-1 -: 32];   // d0..d3
    assign reg_we   = cmd_done && addr_hit;

    // one write per command
    a_we_single : assert property (
        @(posedge mclk) disable iff (rst)
        reg_we |=> !reg_we
    );

endmodule

`default_nettype wire

// File: rtc_pkg.sv
/*
 * rtc_pkg: widths, register indices, byte counts
 * and the last valid microsecond value of the real-time clock
 */
`default_nettype none

package rtc_pkg;

    // time and correction widths
    localparam int SEC_W  = 32;           // whole seconds
    localparam int USEC_W = 20;           // microseconds, 0..999999
    localparam int CORR_W = 16;           // signed rate correction
    localparam int ACC_W  = 24;           // phase accumulator

    // microsecond counter wraps after this value
    localparam logic [USEC_W-1:0] USEC_MAX = 20'd999999;

    // byte-serial framing
    localparam int CMD_BYTES    = 6;      // al, ah, d0..d3
    localparam int STATUS_BYTES = 9;      // addr, seq/snap, sec x4, usec x3

    // register index = low two address bits
    localparam logic [1:0] REG_USEC   = 2'd0; // pending microseconds
    localparam logic [1:0] REG_SEC    = 2'd1; // pending seconds, starts the load
    localparam logic [1:0] REG_CORR   = 2'd2; // rate correction
    localparam logic [1:0] REG_STATUS = 2'd3; // snapshot + status request

endpackage

`default_nettype wire
